// File: pipe_dram.f
verilog/loopback_pkg.sv
verilog/word_fifo.sv
verilog/block_ram.sv
verilog/mem_arbiter.sv
verilog/dma_write_port.sv
verilog/dma_read_port.sv
verilog/pipe_dram_top.sv
sim/tb_clock.sv
sim/pipe_dram_assertions.sv
sim/pipe_dram_tb.sv

// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := pipe_dram_tb
FILELIST   := pipe_dram.f
OBJ_DIR    := obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/pipe_dram_tb.sv
`timescale 1ns/1ns

module pipe_dram_tb;

	localparam int WAIT_LIMIT = 2000;   // Cycles per wait

	logic okClk;
	logic reset_i;
	logic writes_en_i;
	logic reads_en_i;
	logic pipe_in_write_i;
	logic [loopback_pkg::WORD_W-1:0] pipe_in_data_i;
	logic pipe_in_ready_o;
	logic pipe_out_read_i;
	logic [loopback_pkg::WORD_W-1:0] pipe_out_data_o;
	logic pipe_out_ready_o;

	integer seed = 32'h3a3;
	logic [loopback_pkg::WORD_W-1:0] stream [$];   // Every word sent, in order
	int rx_count = 0;
	int check_count = 0;
	int error_count = 0;

	tb_clock clock_gen (.okClk(okClk), .reset_i(reset_i));

	pipe_dram_top pipe_dram_top_inst (
		.okClk(okClk), .reset_i(reset_i),
		.writes_en_i(writes_en_i), .reads_en_i(reads_en_i),
		.pipe_in_write_i(pipe_in_write_i), .pipe_in_data_i(pipe_in_data_i),
		.pipe_in_ready_o(pipe_in_ready_o),
		.pipe_out_read_i(pipe_out_read_i), .pipe_out_data_o(pipe_out_data_o),
		.pipe_out_ready_o(pipe_out_ready_o)
	);

	// Identity loopback in order
	function automatic logic [loopback_pkg::WORD_W-1:0] expected_word(input int idx);
		if (idx < stream.size())
			return stream[idx];
		return 'x;   // Popped more than was sent
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		error_count++;
		finish_run();
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("test %s: %0d errors", name, error_count - start_errors);
	endtask

	// ----------------------------------------
	// Host model
	// ----------------------------------------
	task automatic wait_in_ready(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge okClk);
			cycles++;
		end while (pipe_in_ready_o !== level && cycles <= WAIT_LIMIT);
		if (pipe_in_ready_o !== level)
			abort_run("timed out waiting for pipe_in_ready");
	endtask

	task automatic wait_out_ready();
		int cycles;
		cycles = 0;
		do begin
			@(posedge okClk);
			cycles++;
		end while (pipe_out_ready_o !== 1'b1 && cycles <= WAIT_LIMIT);
		if (pipe_out_ready_o !== 1'b1)
			abort_run("timed out waiting for pipe_out_ready");
	endtask

	task automatic send_blocks(input int blocks);
		logic [loopback_pkg::WORD_W-1:0] word;
		int b;
		int i;
		for (b = 0; b < blocks; b++) begin
			wait_in_ready(1'b1);   // Room for a whole block
			for (i = 0; i < loopback_pkg::BLOCK_WORDS; i++) begin
				word = $random(seed);
				stream.push_back(word);
				pipe_in_write_i <= 1'b1;
				pipe_in_data_i  <= word;
				@(posedge okClk);
			end
			pipe_in_write_i <= 1'b0;
		end
	endtask

	task automatic read_blocks(input int blocks, input bit pauses);
		int b;
		int i;
		int gap;
		for (b = 0; b < blocks; b++) begin
			wait_out_ready();
			for (i = 0; i < loopback_pkg::BLOCK_WORDS; i++) begin
				if (pauses) begin
					gap = $unsigned($random(seed)) % 4;   // Short stall inside the block
					pipe_out_read_i <= 1'b0;
					repeat (gap) @(posedge okClk);
				end
				pipe_out_read_i <= 1'b1;
				@(posedge okClk);
			end
			pipe_out_read_i <= 1'b0;
		end
	endtask

	// Each pop is compared with the sent stream
	always @(posedge okClk) begin
		if (!reset_i && pipe_out_read_i) begin
			check_value(pipe_out_data_o, expected_word(rx_count), "loopback word");
			rx_count = rx_count + 1;
		end
	end

	// No block beyond the ones sent may show up
	task automatic check_drained(input string name);
		int i;
		for (i = 0; i < 40; i++) begin
			@(posedge okClk);
			check_value(32'(pipe_out_ready_o), 32'd0, {name, " extra block"});
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic test_reset();
		int start_errors;
		int cycles;
		int i;
		start_errors = error_count;
		cycles = 0;
		@(posedge okClk);   // First reset edge loads the flops
		do begin
			@(posedge okClk);
			cycles++;
			check_value(32'(pipe_in_ready_o), 32'd0, "pipe_in_ready in reset");
			check_value(32'(pipe_out_ready_o), 32'd0, "pipe_out_ready in reset");
		end while (reset_i && cycles <= WAIT_LIMIT);
		if (reset_i)
			abort_run("timed out waiting for reset release");
		for (i = 0; i < 8; i++) begin
			@(posedge okClk);
			check_value(32'(pipe_in_ready_o), 32'd1, "pipe_in_ready after reset");
			check_value(32'(pipe_out_ready_o), 32'd0, "pipe_out_ready after reset");
		end
		report_test("reset", start_errors);
	endtask

	task automatic run_loopback(input string name, input int blocks, input bit pauses);
		int start_errors;
		start_errors = error_count;
		fork
			send_blocks(blocks);
			read_blocks(blocks, pauses);
		join
		check_drained(name);
		report_test(name, start_errors);
	endtask

	task automatic test_writes_off();
		int start_errors;
		int i;
		start_errors = error_count;
		writes_en_i <= 1'b0;
		send_blocks(3);
		wait_in_ready(1'b0);   // 48 words held
		for (i = 0; i < 40; i++) begin
			@(posedge okClk);
			check_value(32'(pipe_in_ready_o), 32'd0, "pipe_in_ready with writes off");
			check_value(32'(pipe_out_ready_o), 32'd0, "pipe_out_ready with writes off");
		end
		writes_en_i <= 1'b1;
		read_blocks(3, 1'b0);
		check_drained("writes disabled");
		report_test("writes disabled", start_errors);
	endtask

	task automatic test_reads_off();
		int start_errors;
		int i;
		start_errors = error_count;
		reads_en_i <= 1'b0;
		send_blocks(5);
		for (i = 0; i < 60; i++) begin
			@(posedge okClk);
			check_value(32'(pipe_out_ready_o), 32'd0, "pipe_out_ready with reads off");
		end
		reads_en_i <= 1'b1;
		read_blocks(5, 1'b0);
		check_drained("reads disabled");
		report_test("reads disabled", start_errors);
	endtask

	initial begin
		writes_en_i     = 1'b1;
		reads_en_i      = 1'b1;
		pipe_in_write_i = 1'b0;
		pipe_in_data_i  = '0;
		pipe_out_read_i = 1'b0;
		test_reset();
		run_loopback("single block", 1, 1'b0);
		run_loopback("ring wrap", 40, 1'b0);
		test_writes_off();
		test_reads_off();
		run_loopback("host pauses", 20, 1'b1);
		repeat (4) @(posedge okClk);
		finish_run();
	end

endmodule

// File: sim/pipe_dram_assertions.sv
`timescale 1ns/1ns

module pipe_dram_assertions (
	input logic okClk,
	input logic reset_i,
	input logic wr_req,
	input logic wr_ack,
	input logic rd_req,
	input logic rd_ack,
	input logic push,
	input logic full
);

	// ----------------------------------------
	// Arbiter handshake
	// ----------------------------------------
	wr_ack_on_req: assert property (@(posedge okClk) disable iff (reset_i)
		$rose(wr_ack) |-> wr_req) else $error("write ack rose without req");
	rd_ack_on_req: assert property (@(posedge okClk) disable iff (reset_i)
		$rose(rd_ack) |-> rd_req) else $error("read ack rose without req");
	wr_req_held: assert property (@(posedge okClk) disable iff (reset_i)
		wr_req && !wr_ack |=> wr_req) else $error("write req dropped before ack");
	rd_req_held: assert property (@(posedge okClk) disable iff (reset_i)
		rd_req && !rd_ack |=> rd_req) else $error("read req dropped before ack");

	// FIFO overflow
	no_push_full: assert property (@(posedge okClk) disable iff (reset_i) !(push && full))
		else $error("push while FIFO full");

endmodule

bind mem_arbiter pipe_dram_assertions arbiter_checks (
	.okClk(okClk), .reset_i(reset_i), .wr_req(wr_req_i), .wr_ack(wr_ack_o),
	.rd_req(rd_req_i), .rd_ack(rd_ack_o), .push(1'b0), .full(1'b0)
);

bind word_fifo pipe_dram_assertions fifo_checks (
	.okClk(okClk), .reset_i(reset_i), .wr_req(1'b0), .wr_ack(1'b0),
	.rd_req(1'b0), .rd_ack(1'b0), .push(push_i), .full(full_o)
);

// File: sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic okClk,
	output logic reset_i
);

	initial okClk = 1'b0;
	always #5 okClk = ~okClk;   // 10 ns period

	// Reset held over four rising edges
	initial begin
		reset_i = 1'b1;
		repeat (4) @(posedge okClk);
		reset_i <= 1'b0;
	end

endmodule

// File: verilog/pipe_dram_top.sv
`timescale 1ns/1ns

module pipe_dram_top (
	input  logic                            okClk,
	input  logic                            reset_i,
	input  logic                            writes_en_i,
	input  logic                            reads_en_i,
	input  logic                            pipe_in_write_i,
	input  logic [loopback_pkg::WORD_W-1:0] pipe_in_data_i,
	output logic                            pipe_in_ready_o,
	input  logic                            pipe_out_read_i,
	output logic [loopback_pkg::WORD_W-1:0] pipe_out_data_o,
	output logic                            pipe_out_ready_o
);

	logic [loopback_pkg::FIFO_CNT_W-1:0]  pipe_in_count;
	logic [loopback_pkg::FIFO_CNT_W-1:0]  pipe_out_count;
	logic [loopback_pkg::WORD_W-1:0]      pipe_in_head;
	logic [loopback_pkg::WORD_W-1:0]      ram_rd_data;
	logic [loopback_pkg::WORD_W-1:0]      out_data;
	logic                                 pipe_in_pop;
	logic                                 out_push;
	logic [loopback_pkg::BLOCK_IDX_W-1:0] wr_blocks;
	logic [loopback_pkg::BLOCK_IDX_W-1:0] rd_blocks;
	logic                                 wr_req;
	logic                                 wr_ack;
	logic                                 rd_req;
	logic                                 rd_ack;
	logic                                 rd_valid;
	loopback_pkg::mem_req_t               wr_beat;
	loopback_pkg::mem_req_t               rd_beat;
	loopback_pkg::mem_req_t               ram_req;

	// ----------------------------------------
	// Host FIFOs
	// ----------------------------------------
	word_fifo pipe_in_fifo (
		.okClk       (okClk),
		.reset_i     (reset_i),
		.push_i      (pipe_in_write_i),
		.push_data_i (pipe_in_data_i),
		.pop_i       (pipe_in_pop),
		.pop_data_o  (pipe_in_head),
		.empty_o     (),
		.full_o      (),
		.count_o     (pipe_in_count)
	);

	word_fifo pipe_out_fifo (
		.okClk       (okClk),
		.reset_i     (reset_i),
		.push_i      (out_push),
		.push_data_i (out_data),
		.pop_i       (pipe_out_read_i),
		.pop_data_o  (pipe_out_data_o),
		.empty_o     (),
		.full_o      (),
		.count_o     (pipe_out_count)
	);

	// Block throttle, registered toward the host
	always_ff @(posedge okClk) begin
		if (reset_i) begin
			pipe_in_ready_o  <= 1'b0;
			pipe_out_ready_o <= 1'b0;
		end else begin
			// Room for one more block plus margin
			pipe_in_ready_o  <= pipe_in_count <= loopback_pkg::FIFO_CNT_W'(
				loopback_pkg::FIFO_DEPTH - loopback_pkg::FIFO_HEADROOM -
				loopback_pkg::BLOCK_WORDS);
			pipe_out_ready_o <= pipe_out_count >=
				loopback_pkg::FIFO_CNT_W'(loopback_pkg::BLOCK_WORDS);
		end
	end

	// ----------------------------------------
	// DMA ports, arbiter and block memory
	// ----------------------------------------
	dma_write_port dma_write_port_inst (
		.okClk        (okClk),
		.reset_i      (reset_i),
		.writes_en_i  (writes_en_i),
		.fifo_count_i (pipe_in_count),
		.fifo_data_i  (pipe_in_head),
		.fifo_pop_o   (pipe_in_pop),
		.rd_blocks_i  (rd_blocks),
		.wr_blocks_o  (wr_blocks),
		.req_o        (wr_req),
		.ack_i        (wr_ack),
		.beat_o       (wr_beat)
	);

	dma_read_port dma_read_port_inst (
		.okClk       (okClk),
		.reset_i     (reset_i),
		.reads_en_i  (reads_en_i),
		.wr_blocks_i (wr_blocks),
		.rd_blocks_o (rd_blocks),
		.out_count_i (pipe_out_count),
		.req_o       (rd_req),
		.ack_i       (rd_ack),
		.beat_o      (rd_beat),
		.rd_valid_i  (rd_valid),
		.rd_data_i   (ram_rd_data),
		.out_push_o  (out_push),
		.out_data_o  (out_data)
	);

	mem_arbiter mem_arbiter_inst (
		.okClk      (okClk),
		.reset_i    (reset_i),
		.wr_req_i   (wr_req),
		.wr_ack_o   (wr_ack),
		.wr_beat_i  (wr_beat),
		.rd_req_i   (rd_req),
		.rd_ack_o   (rd_ack),
		.rd_beat_i  (rd_beat),
		.ram_req_o  (ram_req),
		.rd_valid_o (rd_valid)
	);

	block_ram block_ram_inst (
		.okClk     (okClk),
		.req_i     (ram_req),
		.rd_data_o (ram_rd_data)
	);

endmodule

// File: verilog/dma_read_port.sv
`timescale 1ns/1ns

module dma_read_port (
	input  logic                                 okClk,
	input  logic                                 reset_i,
	input  logic                                 reads_en_i,
	input  logic [loopback_pkg::BLOCK_IDX_W-1:0] wr_blocks_i,
	output logic [loopback_pkg::BLOCK_IDX_W-1:0] rd_blocks_o,
	input  logic [loopback_pkg::FIFO_CNT_W-1:0]  out_count_i,
	output logic                                 req_o,
	input  logic                                 ack_i,
	output loopback_pkg::mem_req_t               beat_o,
	input  logic                                 rd_valid_i,
	input  logic [loopback_pkg::WORD_W-1:0]      rd_data_i,
	output logic                                 out_push_o,
	output logic [loopback_pkg::WORD_W-1:0]      out_data_o
);

	loopback_pkg::dma_state_e state;
	logic [loopback_pkg::BLOCK_OFS_W-1:0] word_ofs;
	logic can_start;
	logic beat_active;
	logic last_beat;

	// A written block and room for all of it downstream
	assign can_start = reads_en_i
		&& (wr_blocks_i != rd_blocks_o)
		&& (out_count_i <= loopback_pkg::FIFO_CNT_W'(loopback_pkg::FIFO_DEPTH -
			loopback_pkg::BLOCK_WORDS));

	assign beat_active = ack_i && (state == loopback_pkg::REQ || state == loopback_pkg::BURST);
	assign last_beat   = beat_active && (word_ofs == '1);

	always_comb begin
		beat_o.en    = beat_active;
		beat_o.we    = 1'b0;
		beat_o.addr  = {rd_blocks_o[loopback_pkg::MEM_ADDR_W-loopback_pkg::BLOCK_OFS_W-1:0],
			word_ofs};
		beat_o.wdata = '0;
	end

	// ----------------------------------------
	// Returning words into the pipe-out FIFO
	// ----------------------------------------
	assign out_push_o = rd_valid_i
		&& (state == loopback_pkg::BURST || state == loopback_pkg::DRAIN);
	assign out_data_o = rd_data_i;

	always_ff @(posedge okClk) begin
		if (reset_i) begin
			state       <= loopback_pkg::IDLE;
			req_o       <= 1'b0;
			word_ofs    <= '0;
			rd_blocks_o <= '0;
		end else begin
			if (beat_active)
				word_ofs <= word_ofs + 1'b1;
			case (state)
				loopback_pkg::IDLE: begin
					if (can_start) begin
						req_o <= 1'b1;
						state <= loopback_pkg::REQ;
					end
				end
				loopback_pkg::REQ: begin
					if (ack_i)
						state <= loopback_pkg::BURST;
				end
				loopback_pkg::BURST: begin
					if (last_beat)
						state <= loopback_pkg::DRAIN;   // Last word still in flight
				end
				loopback_pkg::DRAIN: begin
					if (rd_valid_i) begin
						req_o       <= 1'b0;
						rd_blocks_o <= rd_blocks_o + 1'b1;
						state       <= loopback_pkg::RELEASE;
					end
				end
				loopback_pkg::RELEASE: begin
					if (!ack_i)
						state <= loopback_pkg::IDLE;
				end
				default: state <= loopback_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: verilog/dma_write_port.sv
`timescale 1ns/1ns

module dma_write_port (
	input  logic                                 okClk,
	input  logic                                 reset_i,
	input  logic                                 writes_en_i,
	input  logic [loopback_pkg::FIFO_CNT_W-1:0]  fifo_count_i,
	input  logic [loopback_pkg::WORD_W-1:0]      fifo_data_i,
	output logic                                 fifo_pop_o,
	input  logic [loopback_pkg::BLOCK_IDX_W-1:0] rd_blocks_i,
	output logic [loopback_pkg::BLOCK_IDX_W-1:0] wr_blocks_o,
	output logic                                 req_o,
	input  logic                                 ack_i,
	output loopback_pkg::mem_req_t               beat_o
);

	loopback_pkg::dma_state_e state;
	logic [loopback_pkg::BLOCK_OFS_W-1:0] word_ofs;
	logic [loopback_pkg::BLOCK_IDX_W-1:0] ring_used;
	logic can_start;
	logic beat_active;
	logic last_beat;

	// Full block waiting and a free slot in the ring
	assign ring_used = wr_blocks_o - rd_blocks_i;
	assign can_start = writes_en_i
		&& (fifo_count_i >= loopback_pkg::FIFO_CNT_W'(loopback_pkg::BLOCK_WORDS))
		&& (ring_used < loopback_pkg::BLOCK_IDX_W'(loopback_pkg::MEM_BLOCKS));

	// Beats start on the ack cycle
	assign beat_active = ack_i && (state == loopback_pkg::REQ || state == loopback_pkg::BURST);
	assign last_beat   = beat_active && (word_ofs == '1);
	assign fifo_pop_o  = beat_active;

	always_comb begin
		beat_o.en    = beat_active;
		beat_o.we    = 1'b1;
		beat_o.addr  = {wr_blocks_o[loopback_pkg::MEM_ADDR_W-loopback_pkg::BLOCK_OFS_W-1:0],
			word_ofs};
		beat_o.wdata = fifo_data_i;   // FIFO head
	end

	always_ff @(posedge okClk) begin
		if (reset_i) begin
			state       <= loopback_pkg::IDLE;
			req_o       <= 1'b0;
			word_ofs    <= '0;
			wr_blocks_o <= '0;
		end else begin
			if (beat_active)
				word_ofs <= word_ofs + 1'b1;   // Wraps to zero after the block
			case (state)
				loopback_pkg::IDLE: begin
					if (can_start) begin
						req_o <= 1'b1;
						state <= loopback_pkg::REQ;
					end
				end
				loopback_pkg::REQ: begin
					if (ack_i)
						state <= loopback_pkg::BURST;
				end
				loopback_pkg::BURST: begin
					if (last_beat) begin
						req_o       <= 1'b0;
						wr_blocks_o <= wr_blocks_o + 1'b1;
						state       <= loopback_pkg::RELEASE;
					end
				end
				loopback_pkg::RELEASE: begin
					if (!ack_i)
						state <= loopback_pkg::IDLE;   // Handshake complete
				end
				default: state <= loopback_pkg::IDLE;
			endcase
		end
	end

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
	input  logic                   okClk,
	input  logic                   reset_i,
	input  logic                   wr_req_i,
	output logic                   wr_ack_o,
	input  loopback_pkg::mem_req_t wr_beat_i,
	input  logic                   rd_req_i,
	output logic                   rd_ack_o,
	input  loopback_pkg::mem_req_t rd_beat_i,
	output loopback_pkg::mem_req_t ram_req_o,
	output logic                   rd_valid_o
);

	loopback_pkg::arb_state_e state;
	logic owner_rd;     // Current owner is the read port
	logic last_rd;      // Read port got the last grant
	logic pick_rd;
	logic owner_req;

	// Round robin when both ask
	assign pick_rd   = rd_req_i && (!wr_req_i || !last_rd);
	assign owner_req = owner_rd ? rd_req_i : wr_req_i;

	assign wr_ack_o = (state == loopback_pkg::GRANT) && !owner_rd;
	assign rd_ack_o = (state == loopback_pkg::GRANT) && owner_rd;

	// ----------------------------------------
	// Four-phase handshake
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (reset_i) begin
			state    <= loopback_pkg::FREE;
			owner_rd <= 1'b0;
			last_rd  <= 1'b1;   // Write port wins the first tie
		end else begin
			case (state)
				loopback_pkg::FREE: begin
					if (wr_req_i || rd_req_i) begin
						owner_rd <= pick_rd;
						last_rd  <= pick_rd;
						state    <= loopback_pkg::GRANT;
					end
				end
				loopback_pkg::GRANT: begin
					if (!owner_req)
						state <= loopback_pkg::WAIT_DROP;   // Ack falls next cycle
				end
				loopback_pkg::WAIT_DROP: state <= loopback_pkg::FREE;   // Turnaround
				default: state <= loopback_pkg::FREE;
			endcase
		end
	end

	// Only the owner reaches the memory
	always_comb begin
		ram_req_o = '0;
		if (state == loopback_pkg::GRANT)
			ram_req_o = owner_rd ? rd_beat_i : wr_beat_i;
	end

	always_ff @(posedge okClk) begin
		if (reset_i)
			rd_valid_o <= 1'b0;
		else
			rd_valid_o <= ram_req_o.en && !ram_req_o.we;   // Lines up with RAM data
	end

endmodule

// File: verilog/block_ram.sv
`timescale 1ns/1ns

module block_ram (
	input  logic                            okClk,
	input  loopback_pkg::mem_req_t          req_i,
	output logic [loopback_pkg::WORD_W-1:0] rd_data_o
);

	// Ring of MEM_BLOCKS blocks, BLOCK_WORDS words each
	logic [loopback_pkg::WORD_W-1:0] mem [loopback_pkg::MEM_BLOCKS * loopback_pkg::BLOCK_WORDS];

	always_ff @(posedge okClk) begin
		if (req_i.en) begin
			if (req_i.we)
				mem[req_i.addr] <= req_i.wdata;
			else
				rd_data_o <= mem[req_i.addr];   // One cycle read latency
		end
	end

endmodule

// File: verilog/word_fifo.sv
`timescale 1ns/1ns

module word_fifo (
	input  logic                                okClk,
	input  logic                                reset_i,
	input  logic                                push_i,
	input  logic [loopback_pkg::WORD_W-1:0]     push_data_i,
	input  logic                                pop_i,
	output logic [loopback_pkg::WORD_W-1:0]     pop_data_o,
	output logic                                empty_o,
	output logic                                full_o,
	output logic [loopback_pkg::FIFO_CNT_W-1:0] count_o
);

	logic [loopback_pkg::WORD_W-1:0] mem [loopback_pkg::FIFO_DEPTH];
	logic [$clog2(loopback_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(loopback_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign empty_o = (count_o == '0);
	assign full_o  = (count_o == loopback_pkg::FIFO_CNT_W'(loopback_pkg::FIFO_DEPTH));
	assign do_push = push_i && !full_o;   // Overflow push dropped
	assign do_pop  = pop_i && !empty_o;

	// Head word always visible
	assign pop_data_o = mem[rd_ptr];

	always_ff @(posedge okClk) begin
		if (reset_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count_o <= count_o + 1'b1;
			else if (do_pop && !do_push)
				count_o <= count_o - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge okClk) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

endmodule

// File: verilog/loopback_pkg.sv
package loopback_pkg;

	// ----------------------------------------
	// Sizes
	// ----------------------------------------
	localparam int WORD_W        = 32;
	localparam int BLOCK_WORDS   = 16;  // Burst length and throttle unit
	localparam int BLOCK_OFS_W   = 4;
	localparam int MEM_BLOCKS    = 16;
	localparam int BLOCK_IDX_W   = 5;   // One extra bit for full vs empty ring
	localparam int MEM_ADDR_W    = 8;
	localparam int FIFO_DEPTH    = 64;
	localparam int FIFO_CNT_W    = 7;
	localparam int FIFO_HEADROOM = 4;

	// One memory beat, from a DMA port through the arbiter to the RAM
	typedef struct packed {
		logic                  en;
		logic                  we;
		logic [MEM_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     wdata;
	} mem_req_t;

	typedef enum logic [2:0] {
		IDLE,
		REQ,
		BURST,
		DRAIN,
		RELEASE
	} dma_state_e;

	typedef enum logic [1:0] {
		FREE,
		GRANT,
		WAIT_DROP
	} arb_state_e;

endpackage
